/* filelist.f */
common/exec_pkg.sv
common/alu_op_if.sv
common/muldiv_if.sv
hw/exec_ctrl.sv
hw/alu.sv
hw/multiplier/mul_pipe.sv
hw/divider/div_serial.sv
hw/exec_unit.sv
verification/exec_unit_chk.sv
verification/tb_exec_unit.sv

/* verification/exec_golden.hex */
// op a b result flags, one operation per line
// flags hold eq, lt and ltu in the low three bits
00 7fffffff 00000001 80000000 0
01 00000005 00000007 fffffffe 3
02 f0f0a5a5 0ff05a5a 00f00000 2
03 12340000 00005678 12345678 0
04 ffffffff 0f0f0f0f f0f0f0f0 2
05 00000001 00000023 00000008 3
06 80000000 0000001f 00000001 2
07 80000000 00000004 f8000000 2
08 ffffffff 00000001 00000001 2
09 ffffffff 00000001 00000000 2
11 aaaa1234 5678bbbb 56781234 2
12 00000001 00000000 80000000 0
13 40000001 00000003 80000005 0
0a 00012345 00006789 75cca2ed 0
0a ffffffff ffffffff 00000001 4
0b 80000000 80000000 40000000 4
0b ffffffff 00000002 ffffffff 2
0b 7fffffff 7fffffff 3fffffff 4
0c fffffff9 00000002 fffffffd 2
0e fffffff9 00000002 ffffffff 2
0d 00000064 00000007 0000000e 0
0f 00000064 00000007 00000002 0
0c 80000000 ffffffff 80000000 3
0e 80000000 ffffffff 00000000 3
0d 12345678 00000000 ffffffff 0
0e 12345678 00000000 12345678 0
10 ff00ff00 0f0f0f0f 00000010 2
14 00000000 00000000 00000020 4
14 00010000 00000000 00000010 0
15 8000ffff 00000000 00000011 2

/* verification/tb_exec_unit.sv */
`timescale 1ns/100ps

module tb_exec_unit;

    localparam int N_OPS       = 30;
    localparam int IDLE_LIMIT  = 200;   // cycles with no result before the run gives up
    localparam int HOLD_AT     = 6;
    localparam int HOLD_CYCLES = 120;
    localparam int SNAP_LEFT   = 30;

    logic                       clk_i;
    logic                       rstn_i;
    logic                       req_valid_i;
    exec_pkg::alu_op_e          req_op_i;
    logic [exec_pkg::XLEN-1:0]  req_a_i;
    logic [exec_pkg::XLEN-1:0]  req_b_i;
    logic                       req_credit_o;
    logic                       res_valid_o;
    logic [exec_pkg::XLEN-1:0]  res_data_o;
    logic                       res_eq_o;
    logic                       res_lt_o;
    logic                       res_ltu_o;
    logic                       res_credit_i;

    logic [31:0]  gold [N_OPS*5];   // op, a, b, result, flags per operation
    int           errors;
    int           sent;
    int           results;
    int           req_credits;
    int           up_credits;      // request credits the testbench holds
    int           returned;
    int           owed;
    int           gap;
    int           hold_left;
    int           snap_res;
    int           snap_req;
    int           idle;
    bit           aborted;

    exec_unit DUT (
        .clk_i        ( clk_i ),
        .rstn_i       ( rstn_i ),
        .req_valid_i  ( req_valid_i ),
        .req_op_i     ( req_op_i ),
        .req_a_i      ( req_a_i ),
        .req_b_i      ( req_b_i ),
        .req_credit_o ( req_credit_o ),
        .res_valid_o  ( res_valid_o ),
        .res_data_o   ( res_data_o ),
        .res_eq_o     ( res_eq_o ),
        .res_lt_o     ( res_lt_o ),
        .res_ltu_o    ( res_ltu_o ),
        .res_credit_i ( res_credit_i )
    );

    always #5 clk_i = ~clk_i;

    function automatic int credit_gap(int n);
        case (n % 4)
            0:       return 0;
            1:       return 3;
            2:       return 1;
            default: return 6;
        endcase
    endfunction

    task automatic compare_result(int idx);
        exec_pkg::alu_op_e  op;
        logic [31:0]        exp_data;
        logic [2:0]         exp_flags;
        logic [2:0]         act_flags;
        string              name;
        op        = exec_pkg::alu_op_e'(gold[idx*5][4:0]);
        exp_data  = gold[idx*5+3];
        exp_flags = gold[idx*5+4][2:0];
        act_flags = {res_eq_o, res_lt_o, res_ltu_o};
        name      = $sformatf("#%0d %s", idx, op.name());
        if (res_data_o !== exp_data) begin
            $display("Error %s result: expected %h, actual %h", name, exp_data, res_data_o);
            errors++;
        end
        if (act_flags !== exp_flags) begin
            $display("Error %s eq/lt/ltu: expected %b, actual %b", name, exp_flags, act_flags);
            errors++;
        end
    endtask

    task automatic verify_stall;
        if (results != snap_res) begin
            $display("results kept arriving while result credits were withheld");
            errors++;
        end
        if (req_credits != snap_req) begin
            $display("request credits kept returning while the queue was stalled");
            errors++;
        end
        if (results != exec_pkg::RES_CREDITS + returned) begin
            $display("Error stall result count: expected %0d, actual %0d",
                     exec_pkg::RES_CREDITS + returned, results);
            errors++;
        end
        if (sent - results != exec_pkg::REQ_DEPTH) begin
            $display("Error stall queue fill: expected %0d, actual %0d",
                     exec_pkg::REQ_DEPTH, sent - results);
            errors++;
        end
    endtask

    // one cycle of traffic, outputs are sampled on the falling edge
    task automatic service_cycle;
        @(negedge clk_i);
        if (req_credit_o) begin
            req_credits++;
            up_credits++;
        end
        if (res_valid_o) begin
            if (results >= exec_pkg::RES_CREDITS + returned) begin
                $display("result %0d arrived without a free result credit", results);
                errors++;
            end
            if (results < N_OPS) begin
                compare_result(results);
            end else begin
                $display("more results than requests");
                errors++;
            end
            results++;
            owed++;
            if (results == HOLD_AT) begin
                hold_left = HOLD_CYCLES;
            end
        end
        res_credit_i = 1'b0;
        if (hold_left > 0) begin
            hold_left--;
            if (hold_left == SNAP_LEFT) begin
                snap_res = results;
                snap_req = req_credits;
            end
            if (hold_left == 0) begin
                verify_stall();
            end
        end else if (gap > 0) begin
            gap--;
        end else if (owed > 0) begin
            res_credit_i = 1'b1;
            owed--;
            returned++;
            gap = credit_gap(returned);
        end
        if (sent < N_OPS && up_credits > 0) begin
            req_valid_i = 1'b1;
            req_op_i    = exec_pkg::alu_op_e'(gold[sent*5][4:0]);
            req_a_i     = gold[sent*5+1];
            req_b_i     = gold[sent*5+2];
            sent++;
            up_credits--;
        end else begin
            req_valid_i = 1'b0;
        end
    endtask

    initial begin
        clk_i        = 1'b0;
        rstn_i       = 1'b0;
        req_valid_i  = 1'b0;
        req_op_i     = exec_pkg::ADD;
        req_a_i      = '0;
        req_b_i      = '0;
        res_credit_i = 1'b0;
        errors       = 0;
        sent         = 0;
        results      = 0;
        req_credits  = 0;
        up_credits   = exec_pkg::REQ_DEPTH;
        returned     = 0;
        owed         = 0;
        gap          = 0;
        hold_left    = 0;
        snap_res     = 0;
        snap_req     = 0;
        idle         = 0;
        aborted      = 1'b0;
        $readmemh("verification/exec_golden.hex", gold);
        if ($isunknown(gold[N_OPS*5-1])) begin
            $display("golden file verification/exec_golden.hex is missing or too short");
            errors++;
            aborted = 1'b1;
        end
        repeat (4) @(negedge clk_i);
        rstn_i = 1'b1;

        while (results < N_OPS && !aborted) begin
            service_cycle();
            idle = (res_valid_o || hold_left > 0) ? 0 : idle + 1;
            if (idle > IDLE_LIMIT) begin
                $display("timeout: no result for %0d cycles, %0d of %0d results seen",
                         IDLE_LIMIT, results, N_OPS);
                errors++;
                aborted = 1'b1;
            end
        end
        if (!aborted) begin
            repeat (20) service_cycle();   // catches late or duplicate pulses
            if (req_credits != N_OPS) begin
                $display("Error request credit total: expected %0d, actual %0d",
                         N_OPS, req_credits);
                errors++;
            end
            if (results != N_OPS) begin
                $display("Error result total: expected %0d, actual %0d", N_OPS, results);
                errors++;
            end
        end

        $display("errors: %0d, results: %0d of %0d", errors, results, N_OPS);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* verification/exec_unit_chk.sv */
`timescale 1ns/100ps

module exec_unit_chk (
    input  logic  clk_i,
    input  logic  rstn_i,
    input  logic  req_valid_i,
    input  logic  res_valid_o,
    input  logic  res_credit_i
);

    int req_sent;
    int res_seen;
    int res_given;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            req_sent  <= 0;
            res_seen  <= 0;
            res_given <= 0;
        end else begin
            req_sent  <= req_sent + int'(req_valid_i);
            res_seen  <= res_seen + int'(res_valid_o);
            res_given <= res_given + int'(res_credit_i);
        end
    end

    one_result_per_op: assert property (@(posedge clk_i) disable iff (!rstn_i)
        res_valid_o |-> res_seen < req_sent)
        else $error("result seen with no request left to answer");

    // an entry freed by a result in this cycle can take a new request
    queue_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
        req_sent + int'(req_valid_i) <= res_seen + int'(res_valid_o) + exec_pkg::REQ_DEPTH)
        else $error("more requests outstanding than queue entries");

    result_credit_bound: assert property (@(posedge clk_i) disable iff (!rstn_i)
        res_valid_o |-> res_seen < res_given + exec_pkg::RES_CREDITS)
        else $error("result sent without a result credit");

    valid_known: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !$isunknown(res_valid_o))
        else $error("res_valid_o is unknown after reset");

endmodule

bind exec_unit exec_unit_chk u_chk (
    .clk_i        ( clk_i ),
    .rstn_i       ( rstn_i ),
    .req_valid_i  ( req_valid_i ),
    .res_valid_o  ( res_valid_o ),
    .res_credit_i ( res_credit_i )
);

/* hw/exec_unit.sv */
`timescale 1ns/100ps

module exec_unit (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       req_valid_i,
    input  exec_pkg::alu_op_e          req_op_i,
    input  logic [exec_pkg::XLEN-1:0]  req_a_i,
    input  logic [exec_pkg::XLEN-1:0]  req_b_i,
    output logic                       req_credit_o,
    output logic                       res_valid_o,
    output logic [exec_pkg::XLEN-1:0]  res_data_o,
    output logic                       res_eq_o,
    output logic                       res_lt_o,
    output logic                       res_ltu_o,
    input  logic                       res_credit_i
);

    alu_op_if aif ();
    muldiv_if mul_bus ();
    muldiv_if div_bus ();

    exec_ctrl u_ctrl (
        .clk_i        ( clk_i ),
        .rstn_i       ( rstn_i ),
        .req_valid_i  ( req_valid_i ),
        .req_op_i     ( req_op_i ),
        .req_a_i      ( req_a_i ),
        .req_b_i      ( req_b_i ),
        .req_credit_o ( req_credit_o ),
        .res_valid_o  ( res_valid_o ),
        .res_data_o   ( res_data_o ),
        .res_eq_o     ( res_eq_o ),
        .res_lt_o     ( res_lt_o ),
        .res_ltu_o    ( res_ltu_o ),
        .res_credit_i ( res_credit_i ),
        .aif          ( aif )
    );

    alu u_alu (
        .clk_i  ( clk_i ),
        .rstn_i ( rstn_i ),
        .aif    ( aif ),
        .mul_o  ( mul_bus ),
        .div_o  ( div_bus )
    );

    mul_pipe u_mul (
        .clk_i  ( clk_i ),
        .rstn_i ( rstn_i ),
        .md     ( mul_bus )
    );

    div_serial u_div (
        .clk_i  ( clk_i ),
        .rstn_i ( rstn_i ),
        .md     ( div_bus )
    );

endmodule

/* hw/divider/div_serial.sv */
`timescale 1ns/100ps

module div_serial (
    input  logic     clk_i,
    input  logic     rstn_i,
    muldiv_if.unit   md
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_DONE
    } state_e;

    state_e                               state_q;
    logic [$clog2(exec_pkg::XLEN)-1:0]    step_q;
    logic [exec_pkg::XLEN-1:0]            quo_q;
    logic [exec_pkg::XLEN-1:0]            rem_q;
    logic [exec_pkg::XLEN-1:0]            dvs_q;
    logic                                 neg_quo_q;
    logic                                 neg_rem_q;
    logic                                 want_rem_q;
    logic                                 sgn_op;
    logic                                 a_neg;
    logic                                 b_neg;
    logic                                 div_zero;
    logic [exec_pkg::XLEN:0]              rem_sh;
    logic [exec_pkg::XLEN:0]              diff;

    assign sgn_op   = md.op inside {exec_pkg::MD_DIV, exec_pkg::MD_REM};
    assign a_neg    = sgn_op && md.a[exec_pkg::XLEN-1];
    assign b_neg    = sgn_op && md.b[exec_pkg::XLEN-1];
    assign div_zero = md.b == '0;

    // one restoring step, the next dividend bit comes out of the quotient register
    assign rem_sh = {rem_q, quo_q[exec_pkg::XLEN-1]};
    assign diff   = rem_sh - {1'b0, dvs_q};

    always_ff @(posedge clk_i) begin
        if (state_q == ST_IDLE && md.start) begin
            want_rem_q <= md.op inside {exec_pkg::MD_REM, exec_pkg::MD_REMU};
            dvs_q      <= b_neg ? -md.b : md.b;
            if (div_zero) begin
                quo_q     <= '1;
                rem_q     <= md.a;   // remainder is the dividend as it came in
                neg_quo_q <= 1'b0;
                neg_rem_q <= 1'b0;
            end else begin
                quo_q     <= a_neg ? -md.a : md.a;
                rem_q     <= '0;
                neg_quo_q <= a_neg ^ b_neg;
                neg_rem_q <= a_neg;
            end
        end else if (state_q == ST_RUN) begin
            quo_q <= {quo_q[exec_pkg::XLEN-2:0], !diff[exec_pkg::XLEN]};
            rem_q <= diff[exec_pkg::XLEN] ? rem_sh[exec_pkg::XLEN-1:0] : diff[exec_pkg::XLEN-1:0];
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            state_q <= ST_IDLE;
            step_q  <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    step_q <= '0;
                    if (md.start) begin
                        state_q <= div_zero ? ST_DONE : ST_RUN;
                    end
                end
                ST_RUN: begin
                    step_q <= step_q + 1'b1;
                    if (step_q == '1) begin
                        state_q <= ST_DONE;
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // MIN / -1 needs no special path, the magnitude quotient wraps to MIN
    assign md.done   = state_q == ST_DONE;
    assign md.result = want_rem_q ? (neg_rem_q ? -rem_q : rem_q)
                                  : (neg_quo_q ? -quo_q : quo_q);

endmodule

/* hw/multiplier/mul_pipe.sv */
`timescale 1ns/100ps

module mul_pipe (
    input  logic     clk_i,
    input  logic     rstn_i,
    muldiv_if.unit   md
);

    logic [exec_pkg::MUL_STAGES-1:0]  vld_q;
    logic [exec_pkg::MUL_STAGES-2:0]  neg_q;
    logic [exec_pkg::MUL_STAGES-2:0]  hi_q;
    logic [exec_pkg::XLEN-1:0]        a_q;
    logic [exec_pkg::XLEN-1:0]        b_q;
    logic [exec_pkg::XLEN-1:0]        pp_ll_q;
    logic [exec_pkg::XLEN-1:0]        pp_lh_q;
    logic [exec_pkg::XLEN-1:0]        pp_hl_q;
    logic [exec_pkg::XLEN-1:0]        pp_hh_q;
    logic [2*exec_pkg::XLEN-1:0]      prod;
    logic [exec_pkg::XLEN-1:0]        res_q;

    // magnitudes are multiplied, so the low word is right for either signedness
    always_comb begin
        prod = {{exec_pkg::XLEN{1'b0}}, pp_ll_q}
             + ({{exec_pkg::XLEN{1'b0}}, pp_lh_q} << (exec_pkg::XLEN/2))
             + ({{exec_pkg::XLEN{1'b0}}, pp_hl_q} << (exec_pkg::XLEN/2))
             + {pp_hh_q, {exec_pkg::XLEN{1'b0}}};
        if (neg_q[exec_pkg::MUL_STAGES-2]) begin
            prod = -prod;
        end
    end

    always_ff @(posedge clk_i) begin
        a_q      <= md.a[exec_pkg::XLEN-1] ? -md.a : md.a;
        b_q      <= md.b[exec_pkg::XLEN-1] ? -md.b : md.b;
        neg_q    <= {neg_q[exec_pkg::MUL_STAGES-3:0], md.a[exec_pkg::XLEN-1] ^ md.b[exec_pkg::XLEN-1]};
        hi_q     <= {hi_q[exec_pkg::MUL_STAGES-3:0], md.op == exec_pkg::MD_MULH};
        pp_ll_q  <= a_q[exec_pkg::XLEN/2-1:0] * b_q[exec_pkg::XLEN/2-1:0];
        pp_lh_q  <= a_q[exec_pkg::XLEN/2-1:0] * b_q[exec_pkg::XLEN-1 -: exec_pkg::XLEN/2];
        pp_hl_q  <= a_q[exec_pkg::XLEN-1 -: exec_pkg::XLEN/2] * b_q[exec_pkg::XLEN/2-1:0];
        pp_hh_q  <= a_q[exec_pkg::XLEN-1 -: exec_pkg::XLEN/2] * b_q[exec_pkg::XLEN-1 -: exec_pkg::XLEN/2];
        res_q    <= hi_q[exec_pkg::MUL_STAGES-2] ? prod[2*exec_pkg::XLEN-1 -: exec_pkg::XLEN]
                                                 : prod[exec_pkg::XLEN-1:0];
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[exec_pkg::MUL_STAGES-2:0], md.start};
        end
    end

    assign md.done   = vld_q[exec_pkg::MUL_STAGES-1];
    assign md.result = res_q;

endmodule

/* hw/alu.sv */
`timescale 1ns/100ps

module alu (
    input  logic         clk_i,
    input  logic         rstn_i,
    alu_op_if.alu        aif,
    muldiv_if.requester  mul_o,
    muldiv_if.requester  div_o
);

    logic [exec_pkg::XLEN-1:0]      result;
    logic [exec_pkg::XLEN-1:0]      cnt_src;
    logic [exec_pkg::CNT_STEP-1:0]  slice;
    logic [exec_pkg::XLEN-1:0]      slice_sum;
    logic                           ctz_hit;
    logic [exec_pkg::CNT_W-1:0]     cnt_q;
    logic [exec_pkg::XLEN-1:0]      acc_q;
    logic                           ctz_hit_q;
    logic                           busy_q;
    logic                           md_done_q;
    logic [exec_pkg::XLEN-1:0]      md_res_q;
    logic                           is_mul;
    logic                           is_div;
    logic                           is_cnt;
    logic                           cnt_last;
    logic                           done;

    assign is_mul   = aif.op inside {exec_pkg::MUL, exec_pkg::MULH};
    assign is_div   = aif.op inside {exec_pkg::DIV, exec_pkg::DIVU, exec_pkg::REM, exec_pkg::REMU};
    assign is_cnt   = aif.op inside {exec_pkg::HDIST, exec_pkg::CTZ, exec_pkg::CPOP};
    assign cnt_last = cnt_q == exec_pkg::CNT_W'(exec_pkg::XLEN / exec_pkg::CNT_STEP);

    // mul/div get the operands straight from the bus, start only in the first cycle
    assign mul_o.a     = aif.a;
    assign mul_o.b     = aif.b;
    assign mul_o.op    = (aif.op == exec_pkg::MULH) ? exec_pkg::MD_MULH : exec_pkg::MD_MUL;
    assign mul_o.start = aif.valid && is_mul && !busy_q;
    assign div_o.a     = aif.a;
    assign div_o.b     = aif.b;
    assign div_o.start = aif.valid && is_div && !busy_q;

    always_comb begin
        case (aif.op)
            exec_pkg::DIVU: div_o.op = exec_pkg::MD_DIVU;
            exec_pkg::REM:  div_o.op = exec_pkg::MD_REM;
            exec_pkg::REMU: div_o.op = exec_pkg::MD_REMU;
            default:        div_o.op = exec_pkg::MD_DIV;
        endcase
    end

    // one CNT_STEP slice per cycle, picked by the sequencer count
    always_comb begin
        cnt_src   = (aif.op == exec_pkg::HDIST) ? aif.a ^ aif.b : aif.a;
        slice     = exec_pkg::CNT_STEP'(cnt_src >> (cnt_q * exec_pkg::CNT_STEP));
        slice_sum = '0;
        ctz_hit   = ctz_hit_q;
        for (int i = 0; i < exec_pkg::CNT_STEP; i++) begin
            if (aif.op != exec_pkg::CTZ) begin
                slice_sum = slice_sum + exec_pkg::XLEN'(slice[i]);
            end else if (!ctz_hit && !slice[i]) begin
                slice_sum = slice_sum + 1'b1;
            end else begin
                ctz_hit = 1'b1;   // zeros above the first set bit do not count
            end
        end
    end

    always_comb begin
        result = '0;
        case (aif.op)
            exec_pkg::ADD:    result = aif.a + aif.b;
            exec_pkg::SUB:    result = aif.a - aif.b;
            exec_pkg::AND:    result = aif.a & aif.b;
            exec_pkg::OR:     result = aif.a | aif.b;
            exec_pkg::XOR:    result = aif.a ^ aif.b;
            exec_pkg::SLL:    result = aif.a << aif.b[4:0];
            exec_pkg::SRL:    result = aif.a >> aif.b[4:0];
            exec_pkg::SRA:    result = $signed(aif.a) >>> aif.b[4:0];
            exec_pkg::SLT:    result = exec_pkg::XLEN'(aif.lt);
            exec_pkg::SLTU:   result = exec_pkg::XLEN'(aif.ltu);
            exec_pkg::PACK:   result = {aif.b[exec_pkg::XLEN-1 -: exec_pkg::XLEN/2],
                                        aif.a[exec_pkg::XLEN/2-1:0]};
            exec_pkg::REV: begin
                for (int i = 0; i < exec_pkg::XLEN; i++) begin
                    result[i] = aif.a[exec_pkg::XLEN-1-i];
                end
            end
            exec_pkg::SH1ADD: result = (aif.a << 1) + aif.b;
            exec_pkg::HDIST,
            exec_pkg::CTZ,
            exec_pkg::CPOP:   result = acc_q;
            default:          result = md_res_q;   // all mul/div ops
        endcase
    end

    always_comb begin
        if (is_mul || is_div) begin
            done = aif.valid && md_done_q;
        end else if (is_cnt) begin
            done = aif.valid && cnt_last;
        end else begin
            done = aif.valid;
        end
    end

    assign aif.done   = done;
    assign aif.result = result;
    assign aif.eq     = aif.a == aif.b;
    assign aif.lt     = $signed(aif.a) < $signed(aif.b);
    assign aif.ltu    = aif.a < aif.b;

    always_ff @(posedge clk_i) begin
        if (mul_o.done) begin
            md_res_q <= mul_o.result;
        end else if (div_o.done) begin
            md_res_q <= div_o.result;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            cnt_q     <= '0;
            acc_q     <= '0;
            ctz_hit_q <= 1'b0;
            busy_q    <= 1'b0;
            md_done_q <= 1'b0;
        end else begin
            if (done || !aif.valid || !is_cnt) begin
                cnt_q     <= '0;
                acc_q     <= '0;
                ctz_hit_q <= 1'b0;
            end else begin
                cnt_q     <= cnt_q + 1'b1;
                acc_q     <= acc_q + slice_sum;
                ctz_hit_q <= ctz_hit;
            end
            busy_q    <= aif.valid && !done && (is_mul || is_div);
            md_done_q <= mul_o.done || div_o.done;   // done reaches the bus a cycle later
        end
    end

endmodule

/* hw/exec_ctrl.sv */
`timescale 1ns/100ps

module exec_ctrl (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       req_valid_i,
    input  exec_pkg::alu_op_e          req_op_i,
    input  logic [exec_pkg::XLEN-1:0]  req_a_i,
    input  logic [exec_pkg::XLEN-1:0]  req_b_i,
    output logic                       req_credit_o,
    output logic                       res_valid_o,
    output logic [exec_pkg::XLEN-1:0]  res_data_o,
    output logic                       res_eq_o,
    output logic                       res_lt_o,
    output logic                       res_ltu_o,
    input  logic                       res_credit_i,
    alu_op_if.ctrl                     aif
);

    exec_pkg::alu_op_e                            q_op [exec_pkg::REQ_DEPTH];
    logic [exec_pkg::XLEN-1:0]                    q_a [exec_pkg::REQ_DEPTH];
    logic [exec_pkg::XLEN-1:0]                    q_b [exec_pkg::REQ_DEPTH];
    logic [$clog2(exec_pkg::REQ_DEPTH)-1:0]       wr_ptr_q;
    logic [$clog2(exec_pkg::REQ_DEPTH)-1:0]       rd_ptr_q;
    logic [$clog2(exec_pkg::REQ_DEPTH+1)-1:0]     count_q;
    logic [$clog2(exec_pkg::RES_CREDITS+1)-1:0]   res_cnt_q;
    logic                                         launched_q;
    logic                                         launch;
    logic                                         pop;

    // the head goes out once a result credit is free, then stays until done
    assign aif.valid = launched_q || (count_q != '0 && res_cnt_q != '0);
    assign aif.op    = q_op[rd_ptr_q];
    assign aif.a     = q_a[rd_ptr_q];
    assign aif.b     = q_b[rd_ptr_q];

    assign launch = aif.valid && !launched_q;   // reserves one result credit
    assign pop    = aif.valid && aif.done;

    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            q_op[wr_ptr_q] <= req_op_i;
            q_a[wr_ptr_q]  <= req_a_i;
            q_b[wr_ptr_q]  <= req_b_i;
        end
        if (pop) begin
            res_data_o <= aif.result;
            res_eq_o   <= aif.eq;
            res_lt_o   <= aif.lt;
            res_ltu_o  <= aif.ltu;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wr_ptr_q     <= '0;
            rd_ptr_q     <= '0;
            count_q      <= '0;
            res_cnt_q    <= ($clog2(exec_pkg::RES_CREDITS+1))'(exec_pkg::RES_CREDITS);
            launched_q   <= 1'b0;
            res_valid_o  <= 1'b0;
            req_credit_o <= 1'b0;
        end else begin
            if (req_valid_i) begin
                wr_ptr_q <= (wr_ptr_q == exec_pkg::REQ_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == exec_pkg::REQ_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q      <= count_q + req_valid_i - pop;
            res_cnt_q    <= res_cnt_q - launch + res_credit_i;
            launched_q   <= aif.valid && !aif.done;
            res_valid_o  <= pop;
            req_credit_o <= pop;   // the freed entry goes back upstream
        end
    end

endmodule

/* common/muldiv_if.sv */
`timescale 1ns/100ps

interface muldiv_if;

    exec_pkg::md_op_e           op;
    logic [exec_pkg::XLEN-1:0]  a;
    logic [exec_pkg::XLEN-1:0]  b;
    logic                       start;   // one cycle, with op, a and b
    logic                       done;
    logic [exec_pkg::XLEN-1:0]  result;

    modport requester (
        output op, a, b, start,
        input  done, result
    );

    modport unit (
        input  op, a, b, start,
        output done, result
    );

endinterface

/* common/alu_op_if.sv */
`timescale 1ns/100ps

interface alu_op_if;

    exec_pkg::alu_op_e          op;
    logic [exec_pkg::XLEN-1:0]  a;
    logic [exec_pkg::XLEN-1:0]  b;
    logic                       valid;   // held with op, a, b until done
    logic                       done;
    logic [exec_pkg::XLEN-1:0]  result;
    logic                       eq;
    logic                       lt;
    logic                       ltu;

    modport ctrl (
        output op, a, b, valid,
        input  done, result, eq, lt, ltu
    );

    modport alu (
        input  op, a, b, valid,
        output done, result, eq, lt, ltu
    );

endinterface

/* common/exec_pkg.sv */
package exec_pkg;

    localparam int XLEN        = 32;
    localparam int CNT_STEP    = 8;   // bits examined per cycle by the bit counts
    localparam int CNT_W       = 3;
    localparam int REQ_DEPTH   = 2;   // also the credits upstream starts with
    localparam int RES_CREDITS = 2;
    localparam int MUL_STAGES  = 3;

    typedef enum logic [4:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        MUL,
        MULH,
        DIV,
        DIVU,
        REM,
        REMU,
        HDIST,
        PACK,
        REV,
        SH1ADD,
        CTZ,
        CPOP
    } alu_op_e;

    typedef enum logic [2:0] {
        MD_MUL,
        MD_MULH,
        MD_DIV,
        MD_DIVU,
        MD_REM,
        MD_REMU
    } md_op_e;

endpackage
